// File: clic_bus_pkg.sv
/*
 * CLIC bus-side definitions
 * Register address map of the core-local interrupt controller,
 * byte-lane layout of the per-interrupt word and the transfer
 * size encoding used on the register bus.
 */

`default_nettype none

package clic_bus_pkg;

  // Global control registers
  localparam logic [15:0] CLICCFG_ADDR    = 16'h0000;
  localparam logic [15:0] CLICINFO_ADDR   = 16'h0004;
  localparam logic [15:0] MINTTHRESH_ADDR = 16'h0008;

  // Interrupt i sits at KID_BASE + 4*i
  localparam logic [15:0] KID_BASE        = 16'h1000;

  // Byte lanes inside one interrupt word
  localparam int KID_LANE_IP   = 0;
  localparam int KID_LANE_IE   = 1;
  localparam int KID_LANE_ATTR = 2;
  localparam int KID_LANE_CTL  = 3;

  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } size_e;

endpackage

`default_nettype wire

// File: clic_irq_pkg.sv
/*
 * CLIC interrupt-side definitions
 * Trigger mode encoding held in the attribute byte and the
 * width of the per-interrupt control byte.
 */

`default_nettype none

package clic_irq_pkg;

  // Width of clicintctl, also the arbitration level width
  localparam int CTL_W = 8;

  // Codes 2 and 3 are treated as level
  typedef enum logic [1:0] {
    TRIG_LEVEL   = 2'd0,
    TRIG_POSEDGE = 2'd1
  } trig_e;

endpackage

`default_nettype wire

// File: clic_busif.sv
/*
 * CLIC bus interface
 * Latches a one-cycle register request, decodes it into global
 * register selects and per-interrupt byte-lane selects, and answers
 * with a one-cycle completion carrying the read data.
 */

`timescale 1ns/1ps
`default_nettype none

module clic_busif import clic_bus_pkg::*; #(
  parameter int INT_NUM = 8
) (
  input  wire                   tcip_clk,
  input  wire                   cpurst_b,
  input  wire                   req_sel,
  input  wire  [15:0]           req_addr,
  input  wire                   req_write,
  input  size_e                 req_size,
  input  wire  [31:0]           req_wdata,
  input  wire  [31:0]           cfg_val,
  input  wire  [31:0]           info_val,
  input  wire  [31:0]           thresh_val,
  input  wire  [INT_NUM*32-1:0] kid_rdata_vec,
  output logic                  rsp_cmplt,
  output logic [31:0]           rsp_rdata,
  output logic                  cfg_sel,
  output logic                  info_sel,
  output logic                  thresh_sel,
  output logic [INT_NUM-1:0]    kid_ip_sel,
  output logic [INT_NUM-1:0]    kid_ie_sel,
  output logic [INT_NUM-1:0]    kid_attr_sel,
  output logic [INT_NUM-1:0]    kid_ctl_sel,
  output logic [31:0]           wr_data,
  output logic                  wr_vld
);

  logic               busy_q;
  logic [15:0]        addr_q;
  logic               write_q;
  size_e              size_q;
  logic [31:0]        wdata_q;
  logic               read_vld;
  logic [13:0]        kid_idx;
  logic [INT_NUM-1:0] kid_sel;
  logic [3:0]         lane_mask;
  logic [31:0]        kid_word;

  //============================================================
  //  Request capture
  //============================================================
  // One-shot: busy lasts exactly the cycle after req_sel
  always_ff @(posedge tcip_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      busy_q <= 1'b0;
    end else begin
      busy_q <= req_sel && !busy_q;
    end
  end

  always_ff @(posedge tcip_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      addr_q  <= '0;
      write_q <= 1'b0;
      size_q  <= SIZE_BYTE;
    end else if (req_sel) begin
      addr_q  <= req_addr;
      write_q <= req_write;
      size_q  <= req_size;
    end
  end

  always_ff @(posedge tcip_clk) begin
    if (req_sel) begin
      wdata_q <= req_wdata;
    end
  end

  assign rsp_cmplt = busy_q;
  assign wr_vld    = busy_q && write_q;
  assign read_vld  = busy_q && !write_q;
  assign wr_data   = wdata_q;

  //============================================================
  //  Address decode
  //============================================================
  assign cfg_sel    = (addr_q == CLICCFG_ADDR);
  assign info_sel   = (addr_q == CLICINFO_ADDR);
  assign thresh_sel = (addr_q == MINTTHRESH_ADDR);

  // Addresses below KID_BASE wrap far above any valid index
  assign kid_idx = addr_q[15:2] - KID_BASE[15:2];

  // Lanes hit by the access, misaligned halfwords and words hit none
  always_comb begin
    case (size_q)
      SIZE_BYTE: lane_mask = 4'b0001 << addr_q[1:0];
      SIZE_HALF: begin
        case (addr_q[1:0])
          2'b00:   lane_mask = 4'b0011;
          2'b10:   lane_mask = 4'b1100;
          default: lane_mask = 4'b0000;
        endcase
      end
      SIZE_WORD: lane_mask = (addr_q[1:0] == 2'b00) ? 4'b1111 : 4'b0000;
      default:   lane_mask = 4'b0000;
    endcase
  end

  for (genvar i = 0; i < INT_NUM; i++) begin : g_kid_sel
    assign kid_sel[i]      = (kid_idx == 14'(i));
    assign kid_ip_sel[i]   = kid_sel[i] && lane_mask[KID_LANE_IP];
    assign kid_ie_sel[i]   = kid_sel[i] && lane_mask[KID_LANE_IE];
    assign kid_attr_sel[i] = kid_sel[i] && lane_mask[KID_LANE_ATTR];
    assign kid_ctl_sel[i]  = kid_sel[i] && lane_mask[KID_LANE_CTL];
  end

  //============================================================
  //  Read data
  //============================================================
  // Full word of the addressed interrupt, size does not matter
  always_comb begin
    kid_word = '0;
    for (int k = 0; k < INT_NUM; k++) begin
      kid_word = kid_word | ({32{kid_sel[k]}} & kid_rdata_vec[k*32 +: 32]);
    end
  end

  assign rsp_rdata = ({32{cfg_sel}}    & cfg_val
                    | {32{info_sel}}   & info_val
                    | {32{thresh_sel}} & thresh_val
                    | kid_word)
                    & {32{read_vld}};

endmodule

`default_nettype wire

// File: clic_ctrl_regs.sv
/*
 * CLIC global control registers
 * Holds cliccfg (nlbits) and mintthresh, and presents the
 * read-only clicinfo word with interrupt count and version.
 */

`timescale 1ns/1ps
`default_nettype none

module clic_ctrl_regs #(
  parameter int INT_NUM = 8
) (
  input  wire         tcip_clk,
  input  wire         cpurst_b,
  input  wire         cfg_sel,
  input  wire         info_sel,
  input  wire         thresh_sel,
  input  wire  [31:0] wr_data,
  input  wire         wr_vld,
  output logic [31:0] cfg_val,
  output logic [31:0] info_val,
  output logic [31:0] thresh_val
);

  localparam logic [7:0] CLIC_VERSION = 8'd1;

  logic [3:0] nlbits_q;
  logic [7:0] thresh_q;
  logic       ctrl_wr;

  // clicinfo is read-only, a write to it lands nowhere
  assign ctrl_wr = wr_vld && !info_sel;

  always_ff @(posedge tcip_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      nlbits_q <= '0;
      thresh_q <= '0;
    end else begin
      if (ctrl_wr && cfg_sel) begin
        nlbits_q <= wr_data[4:1];
      end
      if (ctrl_wr && thresh_sel) begin
        thresh_q <= wr_data[7:0];
      end
    end
  end

  assign cfg_val    = {27'b0, nlbits_q, 1'b0};
  assign thresh_val = {24'b0, thresh_q};
  // Count in 12:0, version in 20:13
  assign info_val   = {11'b0, CLIC_VERSION, 13'(INT_NUM)};

endmodule

`default_nettype wire

// File: clic_int_kid.sv
/*
 * CLIC per-interrupt register block
 * Pending, enable, attribute and control bytes of one interrupt,
 * with level or rising-edge trigger handling of its source.
 */

`timescale 1ns/1ps
`default_nettype none

module clic_int_kid import clic_irq_pkg::*; (
  input  wire              tcip_clk,
  input  wire              cpurst_b,
  input  wire              int_src,
  input  wire              ip_sel,
  input  wire              ie_sel,
  input  wire              attr_sel,
  input  wire              ctl_sel,
  input  wire  [31:0]      wr_data,
  input  wire              wr_vld,
  output logic [31:0]      kid_rdata,
  output logic             int_ip,
  output logic             int_ie,
  output logic [CTL_W-1:0] int_ctl
);

  logic             src_q;
  logic             src_rise;
  logic             ip_q;
  logic             ie_q;
  trig_e            trig_q;
  logic [CTL_W-1:0] ctl_q;
  logic             edge_mode;

  assign edge_mode = (trig_q == TRIG_POSEDGE);
  assign src_rise  = int_src && !src_q;

  always_ff @(posedge tcip_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      src_q <= 1'b0;
    end else begin
      src_q <= int_src;
    end
  end

  // Pending bit
  always_ff @(posedge tcip_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      ip_q <= 1'b0;
    end else if (!edge_mode) begin
      ip_q <= int_src;
    end else if (src_rise) begin
      // Hardware set beats a software clear
      ip_q <= 1'b1;
    end else if (wr_vld && ip_sel) begin
      ip_q <= wr_data[0];
    end
  end

  always_ff @(posedge tcip_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      ie_q   <= 1'b0;
      trig_q <= TRIG_LEVEL;
      ctl_q  <= '0;
    end else begin
      if (wr_vld && ie_sel) begin
        ie_q <= wr_data[8];
      end
      if (wr_vld && attr_sel) begin
        trig_q <= trig_e'(wr_data[18:17]);
      end
      if (wr_vld && ctl_sel) begin
        ctl_q <= wr_data[31:24];
      end
    end
  end

  assign kid_rdata = {ctl_q, 5'b0, trig_q, 1'b0, 7'b0, ie_q, 7'b0, ip_q};
  assign int_ip    = ip_q;
  assign int_ie    = ie_q;
  assign int_ctl   = ctl_q;

endmodule

`default_nettype wire

// File: clic_arbiter.sv
/*
 * CLIC interrupt arbiter
 * Picks the enabled pending interrupt with the highest control
 * level, lowest id on a tie, and signals it when above threshold.
 */

`timescale 1ns/1ps
`default_nettype none

module clic_arbiter import clic_irq_pkg::*; #(
  parameter  int INT_NUM = 8,
  localparam int ID_W    = (INT_NUM > 1) ? $clog2(INT_NUM) : 1
) (
  input  wire  [INT_NUM-1:0]       int_ip_vec,
  input  wire  [INT_NUM-1:0]       int_ie_vec,
  input  wire  [INT_NUM*CTL_W-1:0] int_ctl_vec,
  input  wire  [CTL_W-1:0]         thresh_val,
  output logic                     core_int_vld,
  output logic [ID_W-1:0]          core_int_id,
  output logic [CTL_W-1:0]         core_int_level
);

  logic             found;
  logic [ID_W-1:0]  best_id;
  logic [CTL_W-1:0] best_ctl;
  logic [CTL_W-1:0] cur_ctl;

  // Linear scan, strict compare keeps the lower id on equal levels
  always_comb begin
    found    = 1'b0;
    best_id  = '0;
    best_ctl = '0;
    cur_ctl  = '0;
    for (int i = 0; i < INT_NUM; i++) begin
      cur_ctl = int_ctl_vec[i*CTL_W +: CTL_W];
      if (int_ip_vec[i] && int_ie_vec[i] && (!found || cur_ctl > best_ctl)) begin
        found    = 1'b1;
        best_id  = ID_W'(i);
        best_ctl = cur_ctl;
      end
    end
  end

  assign core_int_vld   = found && (best_ctl > thresh_val);
  assign core_int_id    = best_id;
  assign core_int_level = best_ctl;

endmodule

`default_nettype wire

// File: clic_top.sv
/*
 * CLIC top level
 * Single-hart core-local interrupt controller: bus interface,
 * global registers, one register block per interrupt and arbiter.
 */

`timescale 1ns/1ps
`default_nettype none

module clic_top import clic_bus_pkg::*; #(
  parameter  int INT_NUM = 8,
  localparam int ID_W    = (INT_NUM > 1) ? $clog2(INT_NUM) : 1
) (
  input  wire                tcip_clk,
  input  wire                cpurst_b,
  input  wire                req_sel,
  input  wire  [15:0]        req_addr,
  input  wire                req_write,
  input  size_e              req_size,
  input  wire  [31:0]        req_wdata,
  input  wire  [INT_NUM-1:0] int_src,
  output logic               rsp_cmplt,
  output logic [31:0]        rsp_rdata,
  output logic               core_int_vld,
  output logic [ID_W-1:0]    core_int_id,
  output logic [7:0]         core_int_level
);

  logic                  cfg_sel;
  logic                  info_sel;
  logic                  thresh_sel;
  logic [INT_NUM-1:0]    kid_ip_sel;
  logic [INT_NUM-1:0]    kid_ie_sel;
  logic [INT_NUM-1:0]    kid_attr_sel;
  logic [INT_NUM-1:0]    kid_ctl_sel;
  logic [31:0]           wr_data;
  logic                  wr_vld;
  logic [31:0]           cfg_val;
  logic [31:0]           info_val;
  logic [31:0]           thresh_val;
  logic [INT_NUM*32-1:0] kid_rdata_vec;
  logic [INT_NUM-1:0]    int_ip_vec;
  logic [INT_NUM-1:0]    int_ie_vec;
  logic [INT_NUM*8-1:0]  int_ctl_vec;

  clic_busif #(.INT_NUM(INT_NUM)) i_busif (
    .tcip_clk      (tcip_clk),
    .cpurst_b      (cpurst_b),
    .req_sel       (req_sel),
    .req_addr      (req_addr),
    .req_write     (req_write),
    .req_size      (req_size),
    .req_wdata     (req_wdata),
    .cfg_val       (cfg_val),
    .info_val      (info_val),
    .thresh_val    (thresh_val),
    .kid_rdata_vec (kid_rdata_vec),
    .rsp_cmplt     (rsp_cmplt),
    .rsp_rdata     (rsp_rdata),
    .cfg_sel       (cfg_sel),
    .info_sel      (info_sel),
    .thresh_sel    (thresh_sel),
    .kid_ip_sel    (kid_ip_sel),
    .kid_ie_sel    (kid_ie_sel),
    .kid_attr_sel  (kid_attr_sel),
    .kid_ctl_sel   (kid_ctl_sel),
    .wr_data       (wr_data),
    .wr_vld        (wr_vld)
  );

  clic_ctrl_regs #(.INT_NUM(INT_NUM)) i_ctrl_regs (
    .tcip_clk   (tcip_clk),
    .cpurst_b   (cpurst_b),
    .cfg_sel    (cfg_sel),
    .info_sel   (info_sel),
    .thresh_sel (thresh_sel),
    .wr_data    (wr_data),
    .wr_vld     (wr_vld),
    .cfg_val    (cfg_val),
    .info_val   (info_val),
    .thresh_val (thresh_val)
  );

  //============================================================
  //  Per-interrupt blocks
  //============================================================
  for (genvar i = 0; i < INT_NUM; i++) begin : g_kid
    clic_int_kid i_kid (
      .tcip_clk  (tcip_clk),
      .cpurst_b  (cpurst_b),
      .int_src   (int_src[i]),
      .ip_sel    (kid_ip_sel[i]),
      .ie_sel    (kid_ie_sel[i]),
      .attr_sel  (kid_attr_sel[i]),
      .ctl_sel   (kid_ctl_sel[i]),
      .wr_data   (wr_data),
      .wr_vld    (wr_vld),
      .kid_rdata (kid_rdata_vec[i*32 +: 32]),
      .int_ip    (int_ip_vec[i]),
      .int_ie    (int_ie_vec[i]),
      .int_ctl   (int_ctl_vec[i*8 +: 8])
    );
  end

  clic_arbiter #(.INT_NUM(INT_NUM)) i_arbiter (
    .int_ip_vec     (int_ip_vec),
    .int_ie_vec     (int_ie_vec),
    .int_ctl_vec    (int_ctl_vec),
    .thresh_val     (thresh_val[7:0]),
    .core_int_vld   (core_int_vld),
    .core_int_id    (core_int_id),
    .core_int_level (core_int_level)
  );

endmodule

`default_nettype wire

// File: tb_clic.sv
/*
 * Testbench for the CLIC top level
 * Applies a table of register bus transfers and interrupt source
 * patterns, then checks the read data and the interrupt outputs.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_clic import clic_bus_pkg::*; ();

  localparam int INT_NUM = 8;

  typedef struct packed {
    logic        write;
    logic [15:0] addr;
    size_e       size;
    logic [31:0] wdata;
    logic [7:0]  src;
    logic [31:0] exp_rdata;
    logic        exp_vld;
    logic [2:0]  exp_id;
    logic [7:0]  exp_level;
  } row_t;

  logic         tcip_clk;
  logic         cpurst_b;
  logic         req_sel;
  logic [15:0]  req_addr;
  logic         req_write;
  size_e        req_size;
  logic [31:0]  req_wdata;
  logic [7:0]   int_src;
  logic         rsp_cmplt;
  logic [31:0]  rsp_rdata;
  logic         core_int_vld;
  logic [2:0]   core_int_id;
  logic [7:0]   core_int_level;

  row_t rows[$];
  int   cur_row     = 0;
  int   row_errs    = 0;
  int   checks      = 0;
  int   errors      = 0;
  int   cycles      = 0;
  int   cycle_limit = 0;

  clic_top #(.INT_NUM(INT_NUM)) i_dut (
    .tcip_clk       (tcip_clk),
    .cpurst_b       (cpurst_b),
    .req_sel        (req_sel),
    .req_addr       (req_addr),
    .req_write      (req_write),
    .req_size       (req_size),
    .req_wdata      (req_wdata),
    .int_src        (int_src),
    .rsp_cmplt      (rsp_cmplt),
    .rsp_rdata      (rsp_rdata),
    .core_int_vld   (core_int_vld),
    .core_int_id    (core_int_id),
    .core_int_level (core_int_level)
  );

  initial tcip_clk = 1'b0;
  always #50 tcip_clk = ~tcip_clk;

  // Watchdog
  always @(posedge tcip_clk) begin
    cycles++;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Something failed");
      $finish;
    end
  end

  task automatic add_row(input logic wr, input logic [15:0] addr, input size_e size,
                         input logic [31:0] wdata, input logic [7:0] src,
                         input logic [31:0] rdata, input logic vld,
                         input logic [2:0] id, input logic [7:0] lvl);
    row_t r;
    r.write     = wr;
    r.addr      = addr;
    r.size      = size;
    r.wdata     = wdata;
    r.src       = src;
    r.exp_rdata = rdata;
    r.exp_vld   = vld;
    r.exp_id    = id;
    r.exp_level = lvl;
    rows.push_back(r);
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      row_errs++;
      $display("MISMATCH row %0d %s: got 0x%h expected 0x%h", cur_row, name, got, exp);
    end
  endtask

  //============================================================
  //  Stimulus table
  //============================================================
  // wr, addr, size, wdata, src, rdata, vld, id, level
  task automatic fill_table();
    // Reset values
    add_row(1'b0, 16'h0000, SIZE_WORD, 32'h0, 8'h00, 32'h0000_0000, 1'b0, 3'd0, 8'h00);
    add_row(1'b0, 16'h0004, SIZE_WORD, 32'h0, 8'h00, 32'h0000_2008, 1'b0, 3'd0, 8'h00);
    add_row(1'b0, 16'h0008, SIZE_WORD, 32'h0, 8'h00, 32'h0000_0000, 1'b0, 3'd0, 8'h00);
    add_row(1'b0, 16'h1000, SIZE_WORD, 32'h0, 8'h00, 32'h0000_0000, 1'b0, 3'd0, 8'h00);
    add_row(1'b0, 16'h1004, SIZE_WORD, 32'h0, 8'h00, 32'h0000_0000, 1'b0, 3'd0, 8'h00);
    add_row(1'b0, 16'h1008, SIZE_WORD, 32'h0, 8'h00, 32'h0000_0000, 1'b0, 3'd0, 8'h00);
    add_row(1'b0, 16'h100C, SIZE_WORD, 32'h0, 8'h00, 32'h0000_0000, 1'b0, 3'd0, 8'h00);
    add_row(1'b0, 16'h1010, SIZE_WORD, 32'h0, 8'h00, 32'h0000_0000, 1'b0, 3'd0, 8'h00);
    add_row(1'b0, 16'h1014, SIZE_WORD, 32'h0, 8'h00, 32'h0000_0000, 1'b0, 3'd0, 8'h00);
    add_row(1'b0, 16'h1018, SIZE_WORD, 32'h0, 8'h00, 32'h0000_0000, 1'b0, 3'd0, 8'h00);
    add_row(1'b0, 16'h101C, SIZE_WORD, 32'h0, 8'h00, 32'h0000_0000, 1'b0, 3'd0, 8'h00);
    // Global registers and unmapped read
    add_row(1'b1, 16'h0000, SIZE_WORD, 32'hFFFF_FFFF, 8'h00, 32'h0, 1'b0, 3'd0, 8'h00);
    add_row(1'b0, 16'h0000, SIZE_WORD, 32'h0, 8'h00, 32'h0000_001E, 1'b0, 3'd0, 8'h00);
    add_row(1'b1, 16'h0004, SIZE_WORD, 32'h1234_5678, 8'h00, 32'h0, 1'b0, 3'd0, 8'h00);
    add_row(1'b0, 16'h0004, SIZE_WORD, 32'h0, 8'h00, 32'h0000_2008, 1'b0, 3'd0, 8'h00);
    add_row(1'b0, 16'h0100, SIZE_WORD, 32'h0, 8'h00, 32'h0000_0000, 1'b0, 3'd0, 8'h00);
    // Byte lanes of interrupt 1
    add_row(1'b1, 16'h1007, SIZE_BYTE, 32'hA500_0000, 8'h00, 32'h0, 1'b0, 3'd0, 8'h00);
    add_row(1'b0, 16'h1004, SIZE_WORD, 32'h0, 8'h00, 32'hA500_0000, 1'b0, 3'd0, 8'h00);
    add_row(1'b1, 16'h1004, SIZE_HALF, 32'h0000_0101, 8'h00, 32'h0, 1'b0, 3'd0, 8'h00);
    add_row(1'b0, 16'h1004, SIZE_WORD, 32'h0, 8'h00, 32'hA500_0100, 1'b0, 3'd0, 8'h00);
    add_row(1'b1, 16'h1005, SIZE_HALF, 32'hFFFF_FFFF, 8'h00, 32'h0, 1'b0, 3'd0, 8'h00);
    add_row(1'b0, 16'h1004, SIZE_WORD, 32'h0, 8'h00, 32'hA500_0100, 1'b0, 3'd0, 8'h00);
    // Level interrupt 3
    add_row(1'b1, 16'h100C, SIZE_WORD, 32'h4000_0100, 8'h08, 32'h0, 1'b1, 3'd3, 8'h40);
    add_row(1'b0, 16'h100C, SIZE_WORD, 32'h0, 8'h08, 32'h4000_0101, 1'b1, 3'd3, 8'h40);
    add_row(1'b1, 16'h100C, SIZE_BYTE, 32'h0, 8'h08, 32'h0, 1'b1, 3'd3, 8'h40);
    add_row(1'b0, 16'h100C, SIZE_WORD, 32'h0, 8'h08, 32'h4000_0101, 1'b1, 3'd3, 8'h40);
    add_row(1'b0, 16'h100C, SIZE_WORD, 32'h0, 8'h00, 32'h4000_0100, 1'b0, 3'd0, 8'h00);
    // Arbitration and threshold
    add_row(1'b1, 16'h1014, SIZE_WORD, 32'h6000_0100, 8'h28, 32'h0, 1'b1, 3'd5, 8'h60);
    add_row(1'b1, 16'h100C, SIZE_WORD, 32'h6000_0100, 8'h28, 32'h0, 1'b1, 3'd3, 8'h60);
    add_row(1'b1, 16'h0008, SIZE_WORD, 32'h0000_0060, 8'h28, 32'h0, 1'b0, 3'd3, 8'h60);
    add_row(1'b0, 16'h0008, SIZE_WORD, 32'h0, 8'h28, 32'h0000_0060, 1'b0, 3'd3, 8'h60);
    add_row(1'b1, 16'h0008, SIZE_WORD, 32'h0000_005F, 8'h28, 32'h0, 1'b1, 3'd3, 8'h60);
    add_row(1'b1, 16'h0008, SIZE_WORD, 32'h0, 8'h00, 32'h0, 1'b0, 3'd0, 8'h00);
    // Edge interrupt 6
    add_row(1'b1, 16'h1018, SIZE_WORD, 32'h3002_0100, 8'h00, 32'h0, 1'b0, 3'd0, 8'h00);
    add_row(1'b0, 16'h1018, SIZE_WORD, 32'h0, 8'h40, 32'h3002_0101, 1'b1, 3'd6, 8'h30);
    add_row(1'b0, 16'h1018, SIZE_WORD, 32'h0, 8'h00, 32'h3002_0101, 1'b1, 3'd6, 8'h30);
    add_row(1'b1, 16'h1018, SIZE_BYTE, 32'h0, 8'h00, 32'h0, 1'b0, 3'd0, 8'h00);
    add_row(1'b0, 16'h1018, SIZE_WORD, 32'h0, 8'h00, 32'h3002_0100, 1'b0, 3'd0, 8'h00);
  endtask

  //============================================================
  //  Main sequence
  //============================================================
  initial begin
    int lat;

    cpurst_b  = 1'b0;
    req_sel   = 1'b0;
    req_addr  = '0;
    req_write = 1'b0;
    req_size  = SIZE_BYTE;
    req_wdata = '0;
    int_src   = '0;

    fill_table();
    cycle_limit = 4 * rows.size() + 20;

    repeat (4) @(posedge tcip_clk);
    cpurst_b <= 1'b1;

    foreach (rows[n]) begin
      cur_row  = n;
      row_errs = 0;
      @(posedge tcip_clk);
      req_sel   <= 1'b1;
      req_addr  <= rows[n].addr;
      req_write <= rows[n].write;
      req_size  <= rows[n].size;
      req_wdata <= rows[n].wdata;
      int_src   <= rows[n].src;
      @(posedge tcip_clk);
      req_sel <= 1'b0;

      // Wait for completion
      lat = 1;
      @(negedge tcip_clk);
      while (!rsp_cmplt) begin
        @(negedge tcip_clk);
        lat++;
      end
      checks++;
      if (lat != 1) begin
        errors++;
        row_errs++;
        $display("Row %0d: completion came %0d cycles after the request instead of 1",
                 n, lat);
      end
      compare_value("rsp_rdata", rsp_rdata, rows[n].exp_rdata);

      // Bus idle again and interrupt outputs settled
      @(negedge tcip_clk);
      compare_value("rsp_cmplt", 32'(rsp_cmplt), 32'h0);
      compare_value("rsp_rdata", rsp_rdata, 32'h0);
      compare_value("core_int_vld", 32'(core_int_vld), 32'(rows[n].exp_vld));
      compare_value("core_int_id", 32'(core_int_id), 32'(rows[n].exp_id));
      compare_value("core_int_level", 32'(core_int_level), 32'(rows[n].exp_level));

      if (row_errs == 0) begin
        $display("row %0d ok", n);
      end else begin
        $display("row %0d failed with %0d errors", n, row_errs);
      end
    end

    $display("rows %0d, checks %0d, errors %0d", rows.size(), checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
clic_bus_pkg.sv
clic_irq_pkg.sv
clic_busif.sv
clic_ctrl_regs.sv
clic_int_kid.sv
clic_arbiter.sv
clic_top.sv
tb_clic.sv

// File: Bender.yml
package:
  name: clic

sources:
  - clic_bus_pkg.sv
  - clic_irq_pkg.sv
  - clic_busif.sv
  - clic_ctrl_regs.sv
  - clic_int_kid.sv
  - clic_arbiter.sv
  - clic_top.sv
  - target: simulation
    files:
      - tb_clic.sv
